/* verilog/core_mem_pkg.sv */
//********************
// Shared bus types, address map and timing for the core memory system
// Word address bits 30:10 must be zero for an access to reach a bank
//********************
package core_mem_pkg;

   // Bank count and size
   localparam int NUM_BANKS       = 4;
   localparam int BANK_WORDS_LOG2 = 8;
   localparam int BANK_SEL_W      = $clog2(NUM_BANKS);
   // Word address bits covered by the banks, anything above is unmapped
   localparam int MAP_BITS        = BANK_WORDS_LOG2 + BANK_SEL_W;

   // Wait states per bank, indexed by bank number
   localparam int BANK_WAIT [NUM_BANKS] = '{0, 1, 2, 3};

   // Bus timeout for accesses that no bank answers
   localparam int          BUS_TIMEOUT  = 16;
   localparam int          TIMEOUT_W    = $clog2(BUS_TIMEOUT + 1);
   localparam logic [15:0] BUS_ERR_DATA = 16'hDEAD;

   // Core side request, strobes active low
   typedef struct packed {
      logic [30:0] addr;   // word address
      logic [15:0] dout;
      logic        rd_n;
      logic        wr_n;
      logic        wr_h_n;
      logic        wr_l_n;
   } core_bus_t;

   // Wishbone classic request
   typedef struct packed {
      logic [31:0] adr;    // byte address
      logic [15:0] dat;
      logic [1:0]  sel;
      logic        we;
      logic        cyc;
      logic        stb;
   } wb_req_t;

   // Wishbone response
   typedef struct packed {
      logic [15:0] dat;
      logic        ack;
   } wb_rsp_t;

   // Bank wait-state sequencer
   typedef enum logic [1:0] {IDLE, WAIT, ACK} bank_state_e;

   // Bridge operation in flight
   typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE} bus_op_e;

endpackage

/* verilog/core_wb_bridge.sv */
//********************
// Core strobes must stay stable until wait_n_o is seen high at an edge
// Only unmapped accesses time out, mapped banks always answer
//********************
module core_wb_bridge
   import core_mem_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  core_bus_t   core_i,
   input  logic        unmapped_i,
   input  wb_rsp_t     rsp_i,
   output wb_req_t     req_o,
   output logic [15:0] core_din_o,
   output logic        wait_n_o,
   output logic        bus_err_o
);

   logic                 strobe;
   logic                 timeout;
   logic                 done;
   bus_op_e              op_q;
   logic [TIMEOUT_W-1:0] tmo_cnt_q;

   // Either core strobe low means an access is active
   assign strobe = ~(core_i.rd_n & core_i.wr_n);

   // Wishbone request straight from the core pins
   always_comb begin
      req_o.adr = {core_i.addr, 1'b0};
      req_o.dat = core_i.dout;
      // Reads take both lanes, writes take the lanes the core asks for
      req_o.sel = core_i.wr_n ? 2'b11 : {~core_i.wr_h_n, ~core_i.wr_l_n};
      req_o.we  = ~core_i.wr_n;
      req_o.cyc = strobe;
      req_o.stb = strobe;
   end

   // Timeout fires in the last cycle of an unmapped access
   assign timeout = strobe & unmapped_i & (tmo_cnt_q == TIMEOUT_W'(BUS_TIMEOUT));

   // Transfer completes at the next edge
   assign done = strobe & (rsp_i.ack | timeout);

   // Operation register, latched at the first sampling edge
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         op_q <= OP_IDLE;
      end else if (!strobe || done) begin
         op_q <= OP_IDLE;
      end else if (op_q == OP_IDLE) begin
         op_q <= core_i.wr_n ? OP_READ : OP_WRITE;
      end
   end

   // Counts edges with a strobe active and no answer yet
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tmo_cnt_q <= '0;
      end else if (!strobe || done) begin
         tmo_cnt_q <= '0;
      end else if (tmo_cnt_q != TIMEOUT_W'(BUS_TIMEOUT)) begin
         tmo_cnt_q <= tmo_cnt_q + 1'b1;
      end
   end

   // Core stalls until ack or timeout, combinational from ack
   assign wait_n_o = ~(strobe & ~rsp_i.ack & ~timeout);

   // One cycle error pulse, counter clears at the completion edge
   assign bus_err_o = timeout;

   // Timed out reads see the error word
   assign core_din_o = (timeout && (op_q == OP_READ)) ? BUS_ERR_DATA : rsp_i.dat;

endmodule

/* verilog/wb_addr_decode.sv */
//********************
// Purely combinational, bank number from word address bits 9:8
// Strobes and the unmapped flag are only raised with cyc and stb high
//********************
module wb_addr_decode
   import core_mem_pkg::*;
(
   input  wb_req_t              req_i,
   output logic [NUM_BANKS-1:0] bank_stb_o,
   output logic                 unmapped_o
);

   logic [30:0]           word_addr;
   logic [BANK_SEL_W-1:0] bank_idx;
   logic                  out_of_range;
   logic                  active;

   // Wishbone carries a byte address, banks work on words
   assign word_addr = req_i.adr[31:1];

   // Bank select sits just above the in-bank word bits
   assign bank_idx = word_addr[BANK_WORDS_LOG2 +: BANK_SEL_W];

   // Any bit above the mapped window makes the access unmapped
   assign out_of_range = |word_addr[30:MAP_BITS];

   // Valid Wishbone cycle
   assign active = req_i.cyc & req_i.stb;

   // One hot bank strobe for mapped requests
   always_comb begin
      bank_stb_o = '0;
      for (int k = 0; k < NUM_BANKS; k++) begin
         if (active && !out_of_range && (bank_idx == BANK_SEL_W'(k))) begin
            bank_stb_o[k] = 1'b1;
         end
      end
   end

   // No bank owns it, the bridge times it out
   assign unmapped_o = active & out_of_range;

endmodule

/* verilog/wb_ram_bank.sv */
//********************
// 256 x 16 RAM with byte lanes, ack after WAIT_CYCLES wait states
// Request must be held stable until ack, RAM contents are not reset
//********************
module wb_ram_bank
   import core_mem_pkg::*;
#(
   parameter int WAIT_CYCLES = 0
) (
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  logic    stb_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   // Wait counter wide enough for WAIT_CYCLES-1, at least one bit
   localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

   bank_state_e                 state_q;
   bank_state_e                 state_d;
   logic [CNT_W-1:0]            cnt_q;
   logic [CNT_W-1:0]            cnt_d;
   logic [BANK_WORDS_LOG2-1:0]  word_idx;
   logic [15:0]                 rdata_q;

   // Two byte lanes per word
   logic [1:0][7:0] mem [2**BANK_WORDS_LOG2];

   // In-bank word index, byte address bit 0 is dropped
   assign word_idx = req_i.adr[1 +: BANK_WORDS_LOG2];

   // Sequencer next state
   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      case (state_q)
         IDLE: begin
            if (stb_i) begin
               if (WAIT_CYCLES == 0) begin
                  state_d = ACK;
               end else begin
                  state_d = WAIT;
                  // Stay here WAIT_CYCLES cycles in total
                  cnt_d   = CNT_W'(WAIT_CYCLES - 1);
               end
            end
         end
         WAIT: begin
            if (cnt_q == '0) begin
               state_d = ACK;
            end else begin
               cnt_d = cnt_q - 1'b1;
            end
         end
         ACK: begin
            // Back to idle whatever stb does
            state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   // Write lanes at the completion edge, read word loaded going into ACK
   always_ff @(posedge clk_i) begin
      if ((state_q == ACK) && stb_i && req_i.we) begin
         for (int b = 0; b < 2; b++) begin
            if (req_i.sel[b]) begin
               mem[word_idx][b] <= req_i.dat[8*b +: 8];
            end
         end
      end
      if (state_d == ACK) begin
         rdata_q <= mem[word_idx];
      end
   end

   // Ack is high for the single ACK cycle
   assign rsp_o.ack = (state_q == ACK);
   assign rsp_o.dat = rdata_q;

endmodule

/* verilog/wb_resp_mux.sv */
//********************
// AND-OR merge of bank responses
// At most one bank acks at a time, idle banks contribute zero
//********************
module wb_resp_mux
   import core_mem_pkg::*;
(
   input  wb_rsp_t bank_rsp_i [NUM_BANKS],
   output wb_rsp_t rsp_o
);

   logic [15:0] dat_or;
   logic        ack_or;

   // Each bank's data is gated by its own ack, no select needed
   always_comb begin
      dat_or = '0;
      ack_or = 1'b0;
      for (int k = 0; k < NUM_BANKS; k++) begin
         ack_or = ack_or | bank_rsp_i[k].ack;
         dat_or = dat_or | (bank_rsp_i[k].dat & {16{bank_rsp_i[k].ack}});
      end
   end

   // Zero data when nobody acks
   assign rsp_o.ack = ack_or;
   assign rsp_o.dat = dat_or;

endmodule

/* verilog/core_mem_top.sv */
//********************
// Core bus to four wait-state RAM banks, one transfer in flight
// Unmapped accesses end after BUS_TIMEOUT cycles with an error pulse
//********************
module core_mem_top
   import core_mem_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  core_bus_t   core_i,
   output logic [15:0] core_din_o,
   output logic        wait_n_o,
   output logic        bus_err_o
);

   wb_req_t              wb_req;
   wb_rsp_t              wb_rsp;
   wb_rsp_t              bank_rsp [NUM_BANKS];
   logic [NUM_BANKS-1:0] bank_stb;
   logic                 unmapped;

   // Core strobes to Wishbone, wait_n and timeout
   core_wb_bridge u_bridge (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_i     (core_i),
      .unmapped_i (unmapped),
      .rsp_i      (wb_rsp),
      .req_o      (wb_req),
      .core_din_o (core_din_o),
      .wait_n_o   (wait_n_o),
      .bus_err_o  (bus_err_o)
   );

   // Bank select from the address
   wb_addr_decode u_decode (
      .req_i      (wb_req),
      .bank_stb_o (bank_stb),
      .unmapped_o (unmapped)
   );

   // Banks differ only in their wait states
   for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
      wb_ram_bank #(
         .WAIT_CYCLES (BANK_WAIT[g])
      ) u_bank (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .stb_i   (bank_stb[g]),
         .req_i   (wb_req),
         .rsp_o   (bank_rsp[g])
      );
   end

   // Answers back to the bridge
   wb_resp_mux u_mux (
      .bank_rsp_i (bank_rsp),
      .rsp_o      (wb_rsp)
   );

endmodule

/* testbench/tb_checker.sv */
//********************
// Follows one core transfer at a time with back-to-back transfers allowed
// Bytes never written are masked out of read compares
//********************
module tb_checker
   import core_mem_pkg::*;
(
   input logic        clk_i,
   input logic        rst_n_i,
   input core_bus_t   core_i,
   input logic [15:0] core_din_i,
   input logic        wait_n_i,
   input logic        bus_err_i
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int SHADOW_WORDS = 2**MAP_BITS;

   // Shadow of all banks with one known flag per byte lane
   logic [15:0] shadow [SHADOW_WORDS];
   logic [1:0]  known  [SHADOW_WORDS];
   core_bus_t   req;
   bus_op_e     op;
   logic        busy;
   int          edges;
   int          chk_cnt;
   int          err_cnt;
   int          err_at_start;
   int          tests_run = 0;
   int          tests_failed = 0;
   string       test_name = "none";

   function automatic bit is_unmapped(input logic [30:0] addr);
      return |addr[30:MAP_BITS];
   endfunction

   // Edges after the first sampling edge up to completion
   function automatic int exp_edges(input logic [30:0] addr);
      if (is_unmapped(addr)) begin
         return BUS_TIMEOUT;
      end
      return BANK_WAIT[addr[MAP_BITS-1:BANK_WORDS_LOG2]] + 1;
   endfunction

   function automatic logic [15:0] exp_read(input logic [30:0] addr);
      if (is_unmapped(addr)) begin
         return BUS_ERR_DATA;
      end
      return shadow[addr[MAP_BITS-1:0]];
   endfunction

   function automatic logic [15:0] read_mask(input logic [30:0] addr);
      logic [1:0] k;
      k = is_unmapped(addr) ? 2'b11 : known[addr[MAP_BITS-1:0]];
      return {{8{k[1]}}, {8{k[0]}}};
   endfunction

   task automatic compare_data(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
      chk_cnt++;
      if (exp !== act) begin
         err_cnt++;
         $display("ERROR %s: %s %s at %h, expected %h, actual %h",
                  test_name, op.name(), what, req.addr, exp, act);
      end
   endtask

   task automatic compare_count(input string what, input int exp, input int act);
      chk_cnt++;
      if (exp != act) begin
         err_cnt++;
         $display("ERROR %s: %s %s at %h, expected %0d, actual %0d",
                  test_name, op.name(), what, req.addr, exp, act);
      end
   endtask

   always @(posedge clk_i) begin
      logic                strobe;
      logic                done;
      logic [MAP_BITS-1:0] idx;
      strobe = !(core_i.rd_n && core_i.wr_n);
      if (!rst_n_i) begin
         busy    = 1'b0;
         edges   = 0;
         chk_cnt = 0;
         err_cnt = 0;
         for (int i = 0; i < SHADOW_WORDS; i++) begin
            known[i] = 2'b00;
         end
      end else if (!strobe) begin
         // Quiet bus must show no stall and no error
         chk_cnt++;
         if (!wait_n_i || bus_err_i) begin
            err_cnt++;
            $display("Bus fault in %s: wait_n_o low or bus_err_o high with no access",
                     test_name);
         end
         if (busy) begin
            err_cnt++;
            $display("Bus fault in %s: strobes dropped before the transfer ended", test_name);
         end
         busy = 1'b0;
      end else begin
         // First sampling edge latches the request
         if (!busy) begin
            busy  = 1'b1;
            edges = 0;
            req   = core_i;
            op    = core_i.wr_n ? OP_READ : OP_WRITE;
         end else begin
            edges++;
         end
         done = wait_n_i;
         // Error pulse only in the last cycle of an unmapped access
         compare_count("bus_err_o", int'(done && is_unmapped(req.addr)), int'(bus_err_i));
         if (done) begin
            compare_count("completion edges", exp_edges(req.addr), edges);
            if (op == OP_READ) begin
               // Words never written carry no expected data
               if (read_mask(req.addr) != 16'h0000) begin
                  compare_data("read data", exp_read(req.addr) & read_mask(req.addr),
                               core_din_i & read_mask(req.addr));
               end
            end else if (!is_unmapped(req.addr)) begin
               // Write lanes are the inverted byte strobes
               idx = req.addr[MAP_BITS-1:0];
               if (!req.wr_h_n) begin
                  shadow[idx][15:8] = req.dout[15:8];
                  known[idx][1]     = 1'b1;
               end
               if (!req.wr_l_n) begin
                  shadow[idx][7:0] = req.dout[7:0];
                  known[idx][0]    = 1'b1;
               end
            end
            busy = 1'b0;
         end
      end
   end

   task automatic start_test(input string name);
      test_name    = name;
      err_at_start = err_cnt;
   endtask

   task automatic end_test();
      int errs;
      errs = err_cnt - err_at_start;
      tests_run++;
      if (errs == 0) begin
         $display("Test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("Test %s: FAIL with %0d errors", test_name, errs);
      end
   endtask

   task automatic report_totals();
      $display("Tests %0d, failing tests %0d, checks %0d, errors %0d",
               tests_run, tests_failed, chk_cnt, err_cnt);
   endtask

endmodule

/* testbench/tb_core_mem.sv */
//********************
// Plays the 16-bit core at the top-level pins, one transfer at a time
// Inputs change on falling edges, tb_checker does all the comparing
//********************
module tb_core_mem
   import core_mem_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   // Cycles the core waits for wait_n before it gives up
   localparam int STUCK_CYCLES = 40;
   localparam int RANDOM_OPS   = 200;

   logic        clk_i;
   logic        rst_n_i;
   core_bus_t   core_i;
   logic [15:0] core_din_o;
   logic        wait_n_o;
   logic        bus_err_o;
   // Set once a transfer never completes, later accesses are skipped
   logic        bus_stuck;

   // 4 ns clock
   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   core_mem_top dut (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_i     (core_i),
      .core_din_o (core_din_o),
      .wait_n_o   (wait_n_o),
      .bus_err_o  (bus_err_o)
   );

   tb_checker u_chk (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_i     (core_i),
      .core_din_i (core_din_o),
      .wait_n_i   (wait_n_o),
      .bus_err_i  (bus_err_o)
   );

   // All strobes inactive
   task automatic release_bus();
      core_i.addr   = '0;
      core_i.dout   = '0;
      core_i.rd_n   = 1'b1;
      core_i.wr_n   = 1'b1;
      core_i.wr_h_n = 1'b1;
      core_i.wr_l_n = 1'b1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   // Word address from bank number and in-bank word
   function automatic logic [30:0] bank_addr(input int bank, input int word);
      return {21'd0, 2'(bank), 8'(word)};
   endfunction

   // One core transfer, called on a falling edge and returns on one
   task automatic access(input logic [30:0] addr, input bit write,
                         input logic [1:0] lanes, input logic [15:0] data);
      bit done;
      done = 1'b0;
      if (!bus_stuck) begin
         core_i.addr   = addr;
         core_i.dout   = data;
         core_i.rd_n   = write;
         core_i.wr_n   = !write;
         // lanes[1] is the high byte
         core_i.wr_h_n = !(write && lanes[1]);
         core_i.wr_l_n = !(write && lanes[0]);
         // Edge with wait_n high ends the transfer
         for (int n = 0; n < STUCK_CYCLES && !done; n++) begin
            @(posedge clk_i);
            done = wait_n_o;
         end
         @(negedge clk_i);
         if (!done) begin
            bus_stuck = 1'b1;
            $display("Core bus stuck: wait_n_o stayed low for %0d cycles at address %h",
                     STUCK_CYCLES, addr);
         end
         release_bus();
      end
   endtask

   task automatic read_word(input logic [30:0] addr);
      access(addr, 1'b0, 2'b11, 16'h0000);
   endtask

   task automatic write_word(input logic [30:0] addr, input logic [15:0] data);
      access(addr, 1'b1, 2'b11, data);
   endtask

   task automatic write_byte(input logic [30:0] addr, input logic [1:0] lanes,
                             input logic [15:0] data);
      access(addr, 1'b1, lanes, data);
   endtask

   initial begin
      logic [30:0] addr;
      int          kind;
      void'($urandom(59301));
      bus_stuck = 1'b0;
      release_bus();
      rst_n_i = 1'b0;
      repeat (3) @(negedge clk_i);
      rst_n_i = 1'b1;

      // Bus quiet straight after reset
      u_chk.start_test("reset_idle");
      idle_cycles(4);
      u_chk.end_test();

      u_chk.start_test("word_rw");
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int w = 0; w < 4; w++) begin
            write_word(bank_addr(b, w * 67 + 3), 16'($urandom));
         end
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int w = 0; w < 4; w++) begin
            read_word(bank_addr(b, w * 67 + 3));
         end
      end
      u_chk.end_test();

      // High lane alone, then low lane alone, read after each
      u_chk.start_test("byte_lanes");
      for (int b = 0; b < NUM_BANKS; b++) begin
         addr = bank_addr(b, 100 + b);
         write_word(addr, 16'h1234 + 16'(b));
         write_byte(addr, 2'b10, 16'($urandom));
         read_word(addr);
         write_byte(addr, 2'b01, 16'($urandom));
         read_word(addr);
      end
      u_chk.end_test();

      // Edge counts are checked on every transfer
      u_chk.start_test("bank_timing");
      for (int b = 0; b < NUM_BANKS; b++) begin
         write_word(bank_addr(b, 200), 16'hC0DE ^ 16'(b));
         read_word(bank_addr(b, 200));
         idle_cycles(1);
      end
      u_chk.end_test();

      // Upper address bits set, the aliased word must survive
      u_chk.start_test("unmapped");
      write_word(bank_addr(2, 17), 16'h5A5A);
      for (int k = 10; k <= 30; k += 10) begin
         addr = bank_addr(2, 17) | (31'd1 << k);
         write_word(addr, 16'hFFFF);
         read_word(addr);
      end
      read_word(bank_addr(2, 17));
      u_chk.end_test();

      // Small word pool so reads often hit written data
      u_chk.start_test("random");
      for (int i = 0; i < RANDOM_OPS; i++) begin
         addr = bank_addr(int'($urandom % 4), int'($urandom % 16));
         if ($urandom % 8 == 0) begin
            addr = addr | (31'd1 << (10 + $urandom % 21));
         end
         kind = int'($urandom % 3);
         case (kind)
            0: read_word(addr);
            1: write_word(addr, 16'($urandom));
            default: write_byte(addr, 2'(1 + $urandom % 2), 16'($urandom));
         endcase
         idle_cycles(int'($urandom % 2));
      end
      u_chk.end_test();

      u_chk.report_totals();
      if (!bus_stuck && u_chk.err_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* list.f */
verilog/core_mem_pkg.sv
verilog/core_wb_bridge.sv
verilog/wb_addr_decode.sv
verilog/wb_ram_bank.sv
verilog/wb_resp_mux.sv
verilog/core_mem_top.sv
testbench/tb_checker.sv
testbench/tb_core_mem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the core memory testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   -f list.f --top-module tb_core_mem -o tb_core_mem
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_core_mem)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
   exit 0
fi

echo "Pass line not found in simulation output"
exit 1
